/* tb.f */
+incdir+include
hdl/ppu_video_pkg.sv
hdl/ppu_ctrl_pkg.sv
hdl/n64_vbus_demux.sv
hdl/n64_vinfo_detect.sv
hdl/color_curve.sv
hdl/scanline_dim.sv
hdl/n64_ppu_top.sv
sim/tb_ppu_top.sv

/* Makefile */
# Verilator simulation of the N64 front end

VERILATOR ?= verilator
TOP       ?= tb_ppu_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps -j 0

.PHONY: sim clean

# Pass or fail comes from the log, not the simulator status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "sim: PASS" || \
		(echo "sim: FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_ppu_top.sv */
/*
 * Testbench for the N64 front end: clock and reset, bus driver,
 * stimulus table with reference model, frame generator for the
 * video detection and the video-lost timeout
 */

`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module tb_ppu_top import ppu_video_pkg::*, ppu_ctrl_pkg::*;;

  localparam int NUM_ROWS       = 24;
  localparam int PIX_WAIT_MAX   = 32;
  localparam int STATE_WAIT_MAX = 16;

  // One stimulus row: colours, sync flags and configuration
  typedef struct packed {
    logic [`PPU_COLOR_W_IN-1:0] r;
    logic [`PPU_COLOR_W_IN-1:0] g;
    logic [`PPU_COLOR_W_IN-1:0] b;
    logic                       vsync;
    logic                       hsync;
    ppu_cfg_t                   cfg;
  } stim_row_t;

  logic       n64_clk = 1'b0;
  logic       rst;
  logic       nvdsync;
  vbus_word_u vd;
  ppu_cfg_t   cfg;
  logic       pixel_valid;
  logic       vsync;
  logic       hsync;
  rgb24_t     vd_out;
  ppu_state_t ppu_state;

  stim_row_t   stim_table [NUM_ROWS];
  logic [31:0] rng_state;

  // Reference line parity, follows the pixels sent so far
  logic ref_hs_prev;
  logic ref_vs_prev;
  logic ref_line_odd;

  always #2 n64_clk = ~n64_clk;

  n64_ppu_top i_dut (
    .N64_CLK_i     (n64_clk),
    .rst_i         (rst),
    .nvdsync_i     (nvdsync),
    .vd_i          (vd),
    .config_i      (cfg),
    .pixel_valid_o (pixel_valid),
    .vsync_o       (vsync),
    .hsync_o       (hsync),
    .vd_o          (vd_out),
    .ppu_state_o   (ppu_state)
  );

  // ============================================================
  // Reference model and helpers
  // ============================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic ppu_cfg_t make_cfg(input logic [1:0] lift, input logic m16,
                                        input logic sl_en, input logic [3:0] str);
    ppu_cfg_t c;
    c.lift       = lift;
    c.mode_16bit = m16;
    c.sl_en      = sl_en;
    c.sl_str     = str;
    return c;
  endfunction

  // MSB repetition, then e + ((255 - e) * k) / 8
  function automatic int ref_curve(input int c, input logic m16, input int k);
    int ci;
    int e;
    ci = m16 ? (c & 'h7c) : c;
    e  = ci * 2 + ci / 64;
    return e + ((255 - e) * k) / 8;
  endfunction

  // c - (c * f) / 256 with f = (s + 1) * 16 - 1
  function automatic int ref_dim(input int c, input int s);
    int f;
    f = ((s + 1) << `PPU_SL_STR_SHIFT) - 1;
    return c - (c * f) / 256;
  endfunction

  function automatic vbus_word_u sync_word(input logic vs, input logic hs);
    vbus_word_u w;
    w.nib.pad    = 3'b000;
    w.nib.nvsync = ~vs;
    w.nib.nclamp = 1'b1;
    w.nib.nhsync = ~hs;
    w.nib.ncsync = ~(vs | hs);
    return w;
  endfunction

  task automatic stop_run();
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input int exp, input int act);
    assert (exp == act) else begin
      $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
               $time, name, exp, act);
      stop_run();
    end
  endtask

  // Random colours, fixed sync pattern and configuration
  task automatic set_row(input int idx, input logic vs, input logic hs,
                         input logic [1:0] lift, input logic m16,
                         input logic sl_en, input logic [3:0] str);
    stim_row_t row;
    rng_state = xorshift32(rng_state);
    row.r     = rng_state[6:0];
    rng_state = xorshift32(rng_state);
    row.g     = rng_state[6:0];
    rng_state = xorshift32(rng_state);
    row.b     = rng_state[6:0];
    row.vsync = vs;
    row.hsync = hs;
    row.cfg   = make_cfg(lift, m16, sl_en, str);
    stim_table[idx] = row;
  endtask

  task automatic build_table();
    set_row(0,  1, 0, 0, 0, 0, 0);
    set_row(1,  0, 1, 0, 0, 0, 0);
    set_row(2,  0, 0, 0, 0, 0, 0);
    set_row(3,  0, 1, 1, 0, 0, 0);
    set_row(4,  0, 0, 2, 0, 0, 0);
    set_row(5,  0, 1, 3, 0, 0, 0);
    set_row(6,  0, 0, 3, 0, 0, 0);
    set_row(7,  0, 1, 1, 0, 0, 0);
    set_row(8,  0, 0, 0, 1, 0, 0);
    set_row(9,  0, 1, 2, 1, 0, 0);
    set_row(10, 0, 0, 3, 1, 0, 0);
    set_row(11, 0, 1, 0, 0, 1, 0);
    set_row(12, 0, 0, 0, 0, 1, 3);
    set_row(13, 0, 1, 0, 0, 1, 7);
    set_row(14, 0, 0, 0, 0, 1, 15);
    set_row(15, 0, 1, 2, 0, 1, 9);
    set_row(16, 0, 1, 2, 0, 1, 9);
    set_row(17, 0, 0, 1, 0, 1, 4);
    set_row(18, 0, 1, 1, 0, 1, 4);
    set_row(19, 0, 0, 0, 0, 0, 15);
    set_row(20, 1, 0, 0, 0, 1, 15);
    set_row(21, 1, 1, 0, 0, 1, 2);
    set_row(22, 0, 0, 3, 1, 1, 11);
    set_row(23, 0, 1, 0, 0, 1, 0);
    // Full-scale edges on the first pixel
    stim_table[0].r = 7'h00;
    stim_table[0].g = 7'h7f;
    stim_table[0].b = 7'h40;
  endtask

  // ============================================================
  // Bus driver
  // ============================================================

  task automatic send_sync(input logic vs, input logic hs);
    @(negedge n64_clk);
    nvdsync = 1'b0;
    vd      = sync_word(vs, hs);
  endtask

  task automatic bus_idle();
    @(negedge n64_clk);
    nvdsync  = 1'b1;
    vd.color = '0;
  endtask

  task automatic send_pixel(input stim_row_t row);
    send_sync(row.vsync, row.hsync);
    @(negedge n64_clk);
    nvdsync  = 1'b1;
    vd.color = row.r;
    @(negedge n64_clk);
    vd.color = row.g;
    @(negedge n64_clk);
    vd.color = row.b;
    bus_idle();
  endtask

  // n lines of hsync pulses, closed by a vsync word
  task automatic send_frame(input int n_lines);
    for (int i = 0; i < n_lines; i++) begin
      send_sync(1'b0, 1'b1);
      send_sync(1'b0, 1'b0);
    end
    send_sync(1'b1, 1'b0);
    bus_idle();
    // Status updates one cycle after the closing vsync word
    @(negedge n64_clk);
  endtask

  task automatic wait_pixel();
    int cycles;
    cycles = 0;
    while (!pixel_valid && cycles < PIX_WAIT_MAX) begin
      @(negedge n64_clk);
      cycles++;
    end
    if (!pixel_valid) begin
      $display("Timeout at %0t ns: no output pixel within %0d cycles",
               $time, PIX_WAIT_MAX);
      stop_run();
    end
  endtask

  task automatic wait_state(input logic exp_det, input logic exp_pal, input int max_cycles);
    int cycles;
    cycles = 0;
    while ((ppu_state.vdata_detected !== exp_det || ppu_state.palmode !== exp_pal)
           && cycles < max_cycles) begin
      @(negedge n64_clk);
      cycles++;
    end
    check_value("ppu_state_o.vdata_detected", exp_det, ppu_state.vdata_detected);
    check_value("ppu_state_o.palmode", exp_pal, ppu_state.palmode);
  endtask

  task automatic apply_row(input int idx);
    stim_row_t row;
    int exp_r;
    int exp_g;
    int exp_b;
    row = stim_table[idx];
    cfg = row.cfg;
    // Line parity by the pixel rule
    if (row.vsync && !ref_vs_prev) begin
      ref_line_odd = 1'b0;
    end else if (row.hsync && !ref_hs_prev) begin
      ref_line_odd = ~ref_line_odd;
    end
    ref_hs_prev = row.hsync;
    ref_vs_prev = row.vsync;

    exp_r = ref_curve(row.r, row.cfg.mode_16bit, row.cfg.lift);
    exp_g = ref_curve(row.g, row.cfg.mode_16bit, row.cfg.lift);
    exp_b = ref_curve(row.b, row.cfg.mode_16bit, row.cfg.lift);
    if (row.cfg.sl_en && ref_line_odd) begin
      exp_r = ref_dim(exp_r, row.cfg.sl_str);
      exp_g = ref_dim(exp_g, row.cfg.sl_str);
      exp_b = ref_dim(exp_b, row.cfg.sl_str);
    end

    send_pixel(row);
    wait_pixel();
    check_value("vd_o.r", exp_r, vd_out.r);
    check_value("vd_o.g", exp_g, vd_out.g);
    check_value("vd_o.b", exp_b, vd_out.b);
    check_value("vsync_o", row.vsync, vsync);
    check_value("hsync_o", row.hsync, hsync);
    check_value("ppu_state_o.sl_active", row.cfg.sl_en, ppu_state.sl_active);
    // Output strobe lasts a single cycle
    @(negedge n64_clk);
    check_value("pixel_valid_o", 0, pixel_valid);
  endtask

  // ============================================================
  // Test sequence
  // ============================================================

  initial begin
    rst          = 1'b1;
    nvdsync      = 1'b1;
    vd           = '0;
    cfg          = '0;
    rng_state    = 32'h068fa33c;
    ref_hs_prev  = 1'b0;
    ref_vs_prev  = 1'b0;
    ref_line_odd = 1'b0;
    build_table();

    repeat (8) @(negedge n64_clk);
    rst = 1'b0;
    @(negedge n64_clk);

    // Reset values
    check_value("pixel_valid_o", 0, pixel_valid);
    check_value("vsync_o", 0, vsync);
    check_value("hsync_o", 0, hsync);
    check_value("vd_o", 0, vd_out);
    check_value("ppu_state_o.vdata_detected", 0, ppu_state.vdata_detected);
    check_value("ppu_state_o.palmode", 0, ppu_state.palmode);
    check_value("ppu_state_o.sl_active", cfg.sl_en, ppu_state.sl_active);

    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(i);
    end

    // NTSC frame, then PAL frame
    send_sync(1'b0, 1'b0);
    send_sync(1'b1, 1'b0);
    send_frame(263);
    wait_state(1'b1, 1'b0, STATE_WAIT_MAX);
    send_frame(313);
    wait_state(1'b1, 1'b1, STATE_WAIT_MAX);

    // Video must survive half the timeout, then drop
    repeat (`PPU_VDATA_TIMEOUT / 2) @(negedge n64_clk);
    check_value("ppu_state_o.vdata_detected", 1, ppu_state.vdata_detected);
    wait_state(1'b0, 1'b0, `PPU_VDATA_TIMEOUT);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/n64_ppu_top.sv */
/*
 * Top level of the N64-clock front end: demux, colour curve and
 * scanline stages with video detection, plus the status word
 */

`timescale 1ns/1ps
`default_nettype none

module n64_ppu_top import ppu_video_pkg::*, ppu_ctrl_pkg::*; (
  input  logic       N64_CLK_i,
  input  logic       rst_i,
  input  logic       nvdsync_i,
  input  vbus_word_u vd_i,
  input  ppu_cfg_t   config_i,
  output logic       pixel_valid_o,
  output logic       vsync_o,
  output logic       hsync_o,
  output rgb24_t     vd_o,
  output ppu_state_t ppu_state_o
);

  pix21_t      demux_pix_w;
  logic        demux_valid_w;
  logic        sync_seen_w;
  sync_flags_t sync_w;
  pix24_t      curve_pix_w;
  logic        curve_valid_w;
  pix24_t      out_pix_w;
  logic        vdata_detected_w;
  logic        palmode_w;

  // ============================================================
  // Pipeline stages
  // ============================================================

  n64_vbus_demux i_demux (
    .N64_CLK_i    (N64_CLK_i),
    .rst_i        (rst_i),
    .nvdsync_i    (nvdsync_i),
    .vd_i         (vd_i),
    .mode_16bit_i (config_i.mode_16bit),
    .pix_o        (demux_pix_w),
    .pix_valid_o  (demux_valid_w),
    .sync_seen_o  (sync_seen_w),
    .sync_o       (sync_w)
  );

  n64_vinfo_detect i_vinfo (
    .N64_CLK_i        (N64_CLK_i),
    .rst_i            (rst_i),
    .sync_seen_i      (sync_seen_w),
    .sync_i           (sync_w),
    .vdata_detected_o (vdata_detected_w),
    .palmode_o        (palmode_w)
  );

  color_curve i_curve (
    .N64_CLK_i (N64_CLK_i),
    .rst_i     (rst_i),
    .lift_i    (config_i.lift),
    .pix_i     (demux_pix_w),
    .valid_i   (demux_valid_w),
    .pix_o     (curve_pix_w),
    .valid_o   (curve_valid_w)
  );

  scanline_dim i_scanline (
    .N64_CLK_i (N64_CLK_i),
    .rst_i     (rst_i),
    .sl_en_i   (config_i.sl_en),
    .sl_str_i  (config_i.sl_str),
    .pix_i     (curve_pix_w),
    .valid_i   (curve_valid_w),
    .pix_o     (out_pix_w),
    .valid_o   (pixel_valid_o)
  );

  // ============================================================
  // Outputs and status word
  // ============================================================

  assign vsync_o = out_pix_w.sync.vsync;
  assign hsync_o = out_pix_w.sync.hsync;
  assign vd_o    = out_pix_w.rgb;

  assign ppu_state_o.vdata_detected = vdata_detected_w;
  assign ppu_state_o.palmode        = palmode_w;
  assign ppu_state_o.sl_active      = config_i.sl_en;

endmodule

`default_nettype wire

/* hdl/scanline_dim.sv */
/*
 * Stage 3: horizontal scanline emulation, tracks line parity
 * and dims odd lines by the configured strength
 */

`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module scanline_dim import ppu_video_pkg::*; (
  input  logic                    N64_CLK_i,
  input  logic                    rst_i,
  input  logic                    sl_en_i,
  input  logic [`PPU_SL_STR_W-1:0] sl_str_i,
  input  pix24_t                  pix_i,
  input  logic                    valid_i,
  output pix24_t                  pix_o,
  output logic                    valid_o
);

  // c - (c * f) / 256
  function automatic logic [`PPU_COLOR_W_OUT-1:0] dim_color(
    input logic [`PPU_COLOR_W_OUT-1:0] c,
    input logic [`PPU_COLOR_W_OUT-1:0] f
  );
    logic [2*`PPU_COLOR_W_OUT-1:0] prod;
    prod = c * f;
    return c - prod[2*`PPU_COLOR_W_OUT-1:`PPU_COLOR_W_OUT];
  endfunction

  logic hs_prev_q;
  logic vs_prev_q;
  logic line_odd_q;
  logic hs_rise_w;
  logic vs_rise_w;
  logic cur_odd_w;
  logic [`PPU_COLOR_W_OUT:0]   fac_full_w;
  logic [`PPU_COLOR_W_OUT-1:0] sl_fac_w;
  rgb24_t dimmed_w;

  // Strength 0..15 becomes 15..255
  assign fac_full_w = (({1'b0, {(`PPU_COLOR_W_OUT-`PPU_SL_STR_W){1'b0}}, sl_str_i} + 1'b1)
                       << `PPU_SL_STR_SHIFT) - 1'b1;
  assign sl_fac_w   = fac_full_w[`PPU_COLOR_W_OUT-1:0];

  // Line parity of the current pixel, a vsync rise restarts at line 0
  assign hs_rise_w = valid_i & pix_i.sync.hsync & ~hs_prev_q;
  assign vs_rise_w = valid_i & pix_i.sync.vsync & ~vs_prev_q;
  assign cur_odd_w = vs_rise_w ? 1'b0 : (line_odd_q ^ hs_rise_w);

  assign dimmed_w.r = dim_color(pix_i.rgb.r, sl_fac_w);
  assign dimmed_w.g = dim_color(pix_i.rgb.g, sl_fac_w);
  assign dimmed_w.b = dim_color(pix_i.rgb.b, sl_fac_w);

  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      hs_prev_q  <= 1'b0;
      vs_prev_q  <= 1'b0;
      line_odd_q <= 1'b0;
      valid_o    <= 1'b0;
      pix_o      <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        hs_prev_q  <= pix_i.sync.hsync;
        vs_prev_q  <= pix_i.sync.vsync;
        line_odd_q <= cur_odd_w;
        pix_o.sync <= pix_i.sync;
        pix_o.rgb  <= (sl_en_i && cur_odd_w) ? dimmed_w : pix_i.rgb;
      end
    end
  end

  a_dim_not_brighter: assert property (@(posedge N64_CLK_i) disable iff (rst_i)
    valid_i |=> (pix_o.rgb.r <= $past(pix_i.rgb.r)) &&
                (pix_o.rgb.g <= $past(pix_i.rgb.g)) &&
                (pix_o.rgb.b <= $past(pix_i.rgb.b)))
    else $error("scanline stage raised a colour value");

endmodule

`default_nettype wire

/* hdl/color_curve.sv */
/*
 * Stage 2: expands 7-bit colours to 8 bits by MSB repetition and
 * applies the selectable brightening curve
 */

`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module color_curve import ppu_video_pkg::*; (
  input  logic                  N64_CLK_i,
  input  logic                  rst_i,
  input  logic [`PPU_LIFT_W-1:0] lift_i,
  input  pix21_t                pix_i,
  input  logic                  valid_i,
  output pix24_t                pix_o,
  output logic                  valid_o
);

  // e + ((255 - e) * k) / 8, never above full scale since k < 8
  function automatic logic [`PPU_COLOR_W_OUT-1:0] lift_color(
    input logic [`PPU_COLOR_W_IN-1:0] c,
    input logic [`PPU_LIFT_W-1:0]     k
  );
    logic [`PPU_COLOR_W_OUT-1:0] e;
    logic [`PPU_COLOR_W_OUT-1:0] gap;
    logic [`PPU_COLOR_W_OUT+1:0] gap_k;
    e     = {c, c[`PPU_COLOR_W_IN-1]};
    gap   = {`PPU_COLOR_W_OUT{1'b1}} - e;
    gap_k = gap * k;
    return e + gap_k[`PPU_COLOR_W_OUT+1:3];
  endfunction

  rgb24_t lifted_w;

  assign lifted_w.r = lift_color(pix_i.rgb.r, lift_i);
  assign lifted_w.g = lift_color(pix_i.rgb.g, lift_i);
  assign lifted_w.b = lift_color(pix_i.rgb.b, lift_i);

  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge N64_CLK_i) begin
    if (valid_i) begin
      pix_o.sync <= pix_i.sync;
      pix_o.rgb  <= lifted_w;
    end
  end

endmodule

`default_nettype wire

/* hdl/n64_vinfo_detect.sv */
/*
 * Side stage: detects incoming video and whether the frame
 * line count is PAL or NTSC
 */

`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module n64_vinfo_detect import ppu_video_pkg::*; (
  input  logic        N64_CLK_i,
  input  logic        rst_i,
  input  logic        sync_seen_i,
  input  sync_flags_t sync_i,
  output logic        vdata_detected_o,
  output logic        palmode_o
);

  localparam logic [`PPU_LINE_CNT_W-1:0]    PAL_LINE_MIN = `PPU_PAL_LINE_MIN;
  localparam logic [`PPU_LINE_CNT_W-1:0]    LINE_MAX     = '1;
  localparam logic [`PPU_TIMEOUT_CNT_W-1:0] TIMEOUT      = `PPU_VDATA_TIMEOUT;

  logic hs_prev_q;
  logic vs_prev_q;
  logic hs_rise_w;
  logic vs_rise_w;
  logic timeout_w;
  logic [`PPU_LINE_CNT_W-1:0]    line_cnt_q;
  logic [`PPU_TIMEOUT_CNT_W-1:0] idle_cnt_q;

  assign hs_rise_w = sync_seen_i & sync_i.hsync & ~hs_prev_q;
  assign vs_rise_w = sync_seen_i & sync_i.vsync & ~vs_prev_q;
  assign timeout_w = (idle_cnt_q == TIMEOUT);

  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      hs_prev_q        <= 1'b0;
      vs_prev_q        <= 1'b0;
      line_cnt_q       <= '0;
      idle_cnt_q       <= '0;
      vdata_detected_o <= 1'b0;
      palmode_o        <= 1'b0;
    end else begin
      if (sync_seen_i) begin
        hs_prev_q  <= sync_i.hsync;
        vs_prev_q  <= sync_i.vsync;
        idle_cnt_q <= '0;
      end else if (!timeout_w) begin
        idle_cnt_q <= idle_cnt_q + 1'b1;
      end

      if (timeout_w) begin
        vdata_detected_o <= 1'b0;
        palmode_o        <= 1'b0;
        line_cnt_q       <= '0;
      end

      if (vs_rise_w) begin
        // A line starting with the vsync rise belongs to the new frame
        line_cnt_q       <= hs_rise_w ? LINE_MAX ^ (LINE_MAX - 1'b1) : '0;
        vdata_detected_o <= 1'b1;
        palmode_o        <= (line_cnt_q > PAL_LINE_MIN);
      end else if (hs_rise_w && line_cnt_q != LINE_MAX) begin
        line_cnt_q <= line_cnt_q + 1'b1;
      end
    end
  end

  a_pal_needs_video: assert property (@(posedge N64_CLK_i) disable iff (rst_i)
    palmode_o |-> vdata_detected_o)
    else $error("PAL mode reported without detected video");

endmodule

`default_nettype wire

/* hdl/n64_vbus_demux.sv */
/*
 * Stage 1: demultiplexes the 7-bit N64 video bus into one
 * 21-bit pixel with the sync flags of its sync word
 */

`timescale 1ns/1ps
`default_nettype none

`include "ppu_cfg.svh"

module n64_vbus_demux import ppu_video_pkg::*; (
  input  logic        N64_CLK_i,
  input  logic        rst_i,
  input  logic        nvdsync_i,
  input  vbus_word_u  vd_i,
  input  logic        mode_16bit_i,
  output pix21_t      pix_o,
  output logic        pix_valid_o,
  output logic        sync_seen_o,
  output sync_flags_t sync_o
);

  // Word position after the last sync word, 0 means idle
  logic [1:0] word_cnt_q;
  logic       blue_done_q;
  rgb21_t     rgb_q;
  logic [`PPU_COLOR_W_IN-1:0] color_w;

  // 16-bit mode drops the two LSBs of every colour
  assign color_w = mode_16bit_i ? {vd_i.color[`PPU_COLOR_W_IN-1:2], 2'b00} : vd_i.color;

  // ============================================================
  // Word sequencing and sync decode
  // ============================================================

  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      word_cnt_q  <= 2'd0;
      blue_done_q <= 1'b0;
      pix_valid_o <= 1'b0;
      sync_seen_o <= 1'b0;
      sync_o      <= '0;
    end else begin
      sync_seen_o <= ~nvdsync_i;
      pix_valid_o <= blue_done_q;
      blue_done_q <= 1'b0;
      if (!nvdsync_i) begin
        word_cnt_q   <= 2'd1;
        sync_o.vsync <= ~vd_i.nib.nvsync;
        sync_o.hsync <= ~vd_i.nib.nhsync;
      end else if (word_cnt_q != 2'd0) begin
        // Blue wraps the counter back to idle
        word_cnt_q  <= word_cnt_q + 2'd1;
        blue_done_q <= (word_cnt_q == 2'd3);
      end
    end
  end

  // Colour capture and pixel assembly
  always_ff @(posedge N64_CLK_i) begin
    if (nvdsync_i) begin
      case (word_cnt_q)
        2'd1:    rgb_q.r <= color_w;
        2'd2:    rgb_q.g <= color_w;
        2'd3:    rgb_q.b <= color_w;
        default: ;
      endcase
    end
    if (blue_done_q) begin
      pix_o.sync <= sync_o;
      pix_o.rgb  <= rgb_q;
    end
  end

  // Pixels come at most every fourth cycle
  a_valid_single: assert property (@(posedge N64_CLK_i) disable iff (rst_i)
    pix_valid_o |=> !pix_valid_o)
    else $error("demux pixel strobe high on consecutive cycles");

endmodule

`default_nettype wire

/* hdl/ppu_ctrl_pkg.sv */
/*
 * Control types of the N64 front end: the configuration word
 * and the status word reported back
 */

`default_nettype none

`include "ppu_cfg.svh"

package ppu_ctrl_pkg;

  typedef struct packed {
    logic [`PPU_LIFT_W-1:0]   lift;
    logic                     mode_16bit;
    logic                     sl_en;
    logic [`PPU_SL_STR_W-1:0] sl_str;
  } ppu_cfg_t;

  typedef struct packed {
    logic vdata_detected;
    logic palmode;
    logic sl_active;
  } ppu_state_t;

endpackage

`default_nettype wire

/* hdl/ppu_video_pkg.sv */
/*
 * Video data types of the N64 front end: bus word with its two
 * views, sync flags and the 21-bit and 24-bit pixel structs
 */

`default_nettype none

`include "ppu_cfg.svh"

package ppu_video_pkg;

  // Sync nibble as the N64 drives it, all flags active low
  typedef struct packed {
    logic [2:0] pad;
    logic       nvsync;
    logic       nclamp;
    logic       nhsync;
    logic       ncsync;
  } sync_nib_t;

  // One bus word is either a colour value or the sync nibble
  typedef union packed {
    logic [`PPU_COLOR_W_IN-1:0] color;
    sync_nib_t                  nib;
  } vbus_word_u;

  typedef struct packed {
    logic vsync;
    logic hsync;
  } sync_flags_t;

  typedef struct packed {
    logic [`PPU_COLOR_W_IN-1:0] r;
    logic [`PPU_COLOR_W_IN-1:0] g;
    logic [`PPU_COLOR_W_IN-1:0] b;
  } rgb21_t;

  typedef struct packed {
    logic [`PPU_COLOR_W_OUT-1:0] r;
    logic [`PPU_COLOR_W_OUT-1:0] g;
    logic [`PPU_COLOR_W_OUT-1:0] b;
  } rgb24_t;

  typedef struct packed {
    sync_flags_t sync;
    rgb21_t      rgb;
  } pix21_t;

  typedef struct packed {
    sync_flags_t sync;
    rgb24_t      rgb;
  } pix24_t;

endpackage

`default_nettype wire

/* include/ppu_cfg.svh */
/*
 * Build-time constants for the N64 post-processing front end:
 * colour widths, config field widths, frame line thresholds,
 * the video-lost timeout and the scanline strength mapping
 */

`ifndef PPU_CFG_SVH
`define PPU_CFG_SVH

// Colour depth on the N64 bus and after expansion
`define PPU_COLOR_W_IN      7
`define PPU_COLOR_W_OUT     8

// Configuration field widths
`define PPU_LIFT_W          2
`define PPU_SL_STR_W        4

// Scanline strength s maps to the factor ((s+1) << shift) - 1
`define PPU_SL_STR_SHIFT    4

// Frames with more lines than this are PAL
`define PPU_PAL_LINE_MIN    290
`define PPU_LINE_CNT_W      10

// Cycles without a sync word before video counts as lost
`define PPU_VDATA_TIMEOUT   1024
`define PPU_TIMEOUT_CNT_W   11

`endif
